/* verilog.f */
+incdir+.
fifo_data_pkg.sv
fifo_state_pkg.sv
fifo_ptr_if.sv
fifo_fsm_logic.sv
fifo_ptr_counters.sv
fifo_storage.sv
fifo_top.sv
fifo_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the fifo testbench with verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/100ps \
   -f verilog.f --top-module fifo_tb -o fifo_tb_sim &&
sim_out=$(./obj_dir/fifo_tb_sim) &&
echo "$sim_out" &&
echo "$sim_out" | grep -q "TEST RESULT: PASS" &&
echo "simulation passed" && exit 0 ||
{ echo "simulation failed"; exit 1; }

/* fifo_tb.sv */
`timescale 1ns/100ps

`include "fifo_defines.svh"

module fifo_tb;

   localparam int DEPTH      = 1 << `FIFO_PTR_W;
   localparam int WAIT_LIMIT = 20;

   logic                      clk;
   logic                      rst;
   logic                      add_fifo;
   logic                      pop_fifo;
   fifo_data_pkg::fifo_word_t wr_data;
   fifo_data_pkg::fifo_word_t rd_data;
   logic                      fifo_empty;
   logic                      fifo_full;
   logic                      err;

   // queue model and what it predicts after each edge
   fifo_data_pkg::fifo_word_t model_q[$];
   logic                      exp_empty;
   logic                      exp_full;
   fifo_data_pkg::fifo_word_t exp_head;

   logic [31:0] lfsr_state;
   logic [31:0] rnd;
   string       test_name;
   logic        check_en;
   int          error_count;
   int          errors_at_start;
   int          tests_run;
   int          tests_failed;

   fifo_top UUT (
      .clk        (clk),
      .rst        (rst),
      .add_fifo   (add_fifo),
      .pop_fifo   (pop_fifo),
      .wr_data    (wr_data),
      .rd_data    (rd_data),
      .fifo_empty (fifo_empty),
      .fifo_full  (fifo_full),
      .err        (err)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #2 clk = ~clk;
      end
   end

   // one clock edge of the reference fifo
   function automatic void model_step(input logic reset, input logic add, input logic pop,
                                      input fifo_data_pkg::fifo_word_t din);
      logic push_ok;
      logic pop_ok;
      push_ok = add && (model_q.size() < DEPTH);
      pop_ok  = pop && (model_q.size() > 0);
      if (reset) begin
         model_q.delete();
      end else begin
         if (pop_ok) begin
            void'(model_q.pop_front());
         end
         if (push_ok) begin
            model_q.push_back(din);
         end
      end
      exp_empty = (model_q.size() == 0);
      exp_full  = (model_q.size() == DEPTH);
      exp_head  = (model_q.size() > 0) ? model_q[0] : '0;
   endfunction

   // fibonacci lfsr with taps 32 22 2 1
   // each new feedback bit is also the bit taken
   function automatic logic [31:0] lfsr_bits(input int n);
      logic [31:0] bits;
      logic        fb;
      bits = '0;
      for (int i = 0; i < n; i++) begin
         fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
         lfsr_state = {lfsr_state[30:0], fb};
         bits       = {bits[30:0], fb};
      end
      return bits;
   endfunction

   task automatic compare_outputs();
      assert (fifo_empty === exp_empty) else begin
         $display("[ERROR] %s: fifo_empty expected %0b actual %0b",
                  test_name, exp_empty, fifo_empty);
         error_count++;
      end
      assert (fifo_full === exp_full) else begin
         $display("[ERROR] %s: fifo_full expected %0b actual %0b",
                  test_name, exp_full, fifo_full);
         error_count++;
      end
      assert (err === 1'b0) else begin
         $display("[ERROR] %s: err expected 0 actual %0b", test_name, err);
         error_count++;
      end
      // rd_data only means something while the fifo holds data
      if (!exp_empty) begin
         assert (rd_data === exp_head) else begin
            $display("[ERROR] %s: rd_data expected %02h actual %02h",
                     test_name, exp_head, rd_data);
            error_count++;
         end
      end
   endtask

   // model follows the inputs sampled at the edge
   // outputs are compared mid cycle
   always begin
      @(posedge clk);
      model_step(rst, add_fifo, pop_fifo, wr_data);
      @(negedge clk);
      if (check_en) begin
         compare_outputs();
      end
   end

   task automatic drive(input logic add, input logic pop, input fifo_data_pkg::fifo_word_t din);
      @(posedge clk);
      #1;
      add_fifo = add;
      pop_fifo = pop;
      wr_data  = din;
   endtask

   task automatic wait_for_flags(input logic want_empty, input logic want_full);
      int   cycles;
      logic done;
      cycles = 0;
      done   = (fifo_empty === want_empty) && (fifo_full === want_full);
      while (!done && cycles < WAIT_LIMIT) begin
         @(posedge clk);
         #1;
         cycles++;
         done = (fifo_empty === want_empty) && (fifo_full === want_full);
      end
      if (!done) begin
         $display("%s: timed out waiting for fifo_empty=%0b and fifo_full=%0b",
                  test_name, want_empty, want_full);
         error_count++;
      end
   endtask

   task automatic expect_head(input fifo_data_pkg::fifo_word_t word);
      assert (rd_data === word) else begin
         $display("[ERROR] %s: rd_data expected %02h actual %02h", test_name, word, rd_data);
         error_count++;
      end
   endtask

   task automatic begin_test(input string name);
      test_name       = name;
      errors_at_start = error_count;
   endtask

   task automatic finish_test();
      // two idle cycles so the last operation has been compared
      drive(1'b0, 1'b0, '0);
      drive(1'b0, 1'b0, '0);
      tests_run++;
      if (error_count != errors_at_start) begin
         tests_failed++;
         $display("%s: failed with %0d errors", test_name, error_count - errors_at_start);
      end else begin
         $display("%s: ok", test_name);
      end
   endtask

   initial begin
      rst          = 1'b1;
      add_fifo     = 1'b0;
      pop_fifo     = 1'b0;
      wr_data      = '0;
      check_en     = 1'b0;
      lfsr_state   = 32'h4b6d_9eef;
      error_count  = 0;
      tests_run    = 0;
      tests_failed = 0;
      test_name    = "reset";

      repeat (8) @(posedge clk);
      #1;
      rst      = 1'b0;
      check_en = 1'b1;

      begin_test("reset_flags");
      wait_for_flags(1'b1, 1'b0);
      assert (err === 1'b0) else begin
         $display("[ERROR] %s: err expected 0 actual %0b", test_name, err);
         error_count++;
      end
      finish_test();

      begin_test("pop_while_empty");
      drive(1'b0, 1'b1, '0);
      drive(1'b0, 1'b1, '0);
      drive(1'b1, 1'b0, 8'h5a);
      drive(1'b0, 1'b1, '0);
      finish_test();

      begin_test("fill_four");
      drive(1'b1, 1'b0, 8'h11);
      drive(1'b1, 1'b0, 8'h22);
      drive(1'b1, 1'b0, 8'h33);
      drive(1'b1, 1'b0, 8'h44);
      drive(1'b0, 1'b0, '0);
      wait_for_flags(1'b0, 1'b1);
      finish_test();

      // the head is checked while each pop is applied, before its edge
      begin_test("push_while_full_then_drain");
      drive(1'b1, 1'b0, 8'h99);
      drive(1'b0, 1'b1, '0);
      expect_head(8'h11);
      drive(1'b0, 1'b1, '0);
      expect_head(8'h22);
      drive(1'b0, 1'b1, '0);
      expect_head(8'h33);
      drive(1'b0, 1'b1, '0);
      expect_head(8'h44);
      drive(1'b0, 1'b0, '0);
      wait_for_flags(1'b1, 1'b0);
      finish_test();

      begin_test("push_pop_same_cycle");
      drive(1'b1, 1'b0, 8'ha1);
      drive(1'b1, 1'b0, 8'ha2);
      drive(1'b1, 1'b1, 8'hb1);
      drive(1'b1, 1'b1, 8'hb2);
      drive(1'b1, 1'b1, 8'hb3);
      drive(1'b1, 1'b1, 8'hb4);
      drive(1'b0, 1'b1, '0);
      drive(1'b0, 1'b1, '0);
      drive(1'b0, 1'b0, '0);
      wait_for_flags(1'b1, 1'b0);
      finish_test();

      begin_test("random_traffic");
      repeat (300) begin
         rnd = lfsr_bits(10);
         drive(rnd[9], rnd[8], rnd[7:0]);
      end
      finish_test();

      $display("tests run %0d, tests failed %0d, check errors %0d",
               tests_run, tests_failed, error_count);
      if (error_count == 0 && tests_failed == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

/* fifo_top.sv */
`timescale 1ns/100ps

`include "fifo_defines.svh"

module fifo_top (
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       add_fifo,
   input  logic                       pop_fifo,
   input  fifo_data_pkg::fifo_word_t  wr_data,
   output fifo_data_pkg::fifo_word_t  rd_data,
   output logic                       fifo_empty,
   output logic                       fifo_full,
   output logic                       err
);

   // pointers and counter controls between fsm and counters
   fifo_ptr_if ptr_bus ();

   // control state machine
   fifo_fsm_logic u_fsm (
      .clk        (clk),
      .rst        (rst),
      .add_fifo   (add_fifo),
      .pop_fifo   (pop_fifo),
      .ptr        (ptr_bus.fsm_mp),
      .fifo_empty (fifo_empty),
      .fifo_full  (fifo_full),
      .err        (err)
   );

   // read and write pointers
   fifo_ptr_counters u_ctrs (
      .clk (clk),
      .rst (rst),
      .ptr (ptr_bus.ctr_mp)
   );

   // the write enable doubles as the storage write strobe
   fifo_storage u_mem (
      .clk       (clk),
      .write_en  (ptr_bus.write_ctr_en),
      .write_ptr (ptr_bus.write_ptr),
      .read_ptr  (ptr_bus.read_ptr),
      .wr_data   (wr_data),
      .rd_data   (rd_data)
   );

endmodule

/* fifo_storage.sv */
`timescale 1ns/100ps

`include "fifo_defines.svh"

module fifo_storage (
   input  logic                       clk,
   input  logic                       write_en,
   input  fifo_data_pkg::fifo_ptr_t   write_ptr,
   input  fifo_data_pkg::fifo_ptr_t   read_ptr,
   input  fifo_data_pkg::fifo_word_t  wr_data,
   output fifo_data_pkg::fifo_word_t  rd_data
);

   // one entry per pointer value
   localparam int unsigned DEPTH = 1 << `FIFO_PTR_W;

   fifo_data_pkg::fifo_word_t mem [DEPTH];

   // write on the same edge the write counter steps
   always_ff @(posedge clk) begin
      if (write_en) begin
         mem[write_ptr] <= wr_data;
      end
   end

   // show-ahead read
   // the head word is visible as soon as the read pointer moves
   assign rd_data = mem[read_ptr];

endmodule

/* fifo_ptr_counters.sv */
`timescale 1ns/100ps

`include "fifo_defines.svh"

module fifo_ptr_counters (
   input  logic        clk,
   input  logic        rst,
   fifo_ptr_if.ctr_mp  ptr
);

   fifo_data_pkg::fifo_ptr_t read_cnt;
   fifo_data_pkg::fifo_ptr_t write_cnt;

   // one counter step
   // clear wins over increment
   // wraps at the top of the range
   function automatic fifo_data_pkg::fifo_ptr_t step_count(
      input fifo_data_pkg::fifo_ptr_t cur,
      input logic                     inc,
      input logic                     clr
   );
      fifo_data_pkg::fifo_ptr_t nxt;
      nxt = cur;
      if (clr) begin
         nxt = '0;
      end else if (inc) begin
         nxt = fifo_data_pkg::fifo_ptr_t'(cur + 1'b1);
      end
      return nxt;
   endfunction

   always_ff @(posedge clk) begin
      if (rst) begin
         read_cnt <= '0;
      end else begin
         read_cnt <= step_count(read_cnt, ptr.read_ctr_en, ptr.read_ctr_rst);
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         write_cnt <= '0;
      end else begin
         write_cnt <= step_count(write_cnt, ptr.write_ctr_en, ptr.write_ctr_rst);
      end
   end

   assign ptr.read_ptr  = read_cnt;
   assign ptr.write_ptr = write_cnt;

   // the fsm never asks for a step and a recovery clear at once
   assert property (@(posedge clk) disable iff (rst)
      !((ptr.read_ctr_en && ptr.read_ctr_rst) || (ptr.write_ctr_en && ptr.write_ctr_rst)))
      else $error("counter increment during recovery reset");

endmodule

/* fifo_fsm_logic.sv */
`timescale 1ns/100ps

`include "fifo_defines.svh"

module fifo_fsm_logic (
   input  logic         clk,
   input  logic         rst,
   input  logic         add_fifo,
   input  logic         pop_fifo,
   fifo_ptr_if.fsm_mp   ptr,
   output logic         fifo_empty,
   output logic         fifo_full,
   output logic         err
);

   fifo_state_pkg::fifo_state_t state;
   fifo_state_pkg::fifo_state_t next_state;

   // pointer values after one more increment
   fifo_data_pkg::fifo_ptr_t wr_ptr_inc;
   fifo_data_pkg::fifo_ptr_t rd_ptr_inc;

   // a lone write or a lone read in the partly filled state
   logic lone_write;
   logic lone_read;

   assign wr_ptr_inc = fifo_data_pkg::fifo_ptr_t'(ptr.write_ptr + 1'b1);
   assign rd_ptr_inc = fifo_data_pkg::fifo_ptr_t'(ptr.read_ptr + 1'b1);

   assign lone_write = add_fifo & ~pop_fifo;
   assign lone_read  = pop_fifo & ~add_fifo;

   // next state, counter enables and error decode
   always_comb begin
      next_state        = state;
      ptr.read_ctr_en   = 1'b0;
      ptr.write_ctr_en  = 1'b0;
      ptr.read_ctr_rst  = 1'b0;
      ptr.write_ctr_rst = 1'b0;
      err               = 1'b0;

      if (rst) begin
         next_state = fifo_state_pkg::st_empty;
      end else begin
         case (state)
            fifo_state_pkg::st_empty: begin
               // nothing to read, so only a push gets through
               ptr.write_ctr_en = add_fifo;
               if (add_fifo) begin
                  next_state = fifo_state_pkg::st_going_full;
               end
            end

            fifo_state_pkg::st_going_full: begin
               // neither empty nor full here, so both strobes are taken
               ptr.read_ctr_en  = pop_fifo;
               ptr.write_ctr_en = add_fifo;

               // write pointer catching up with the read pointer means full
               if (lone_write && (wr_ptr_inc == ptr.read_ptr)) begin
                  next_state = fifo_state_pkg::st_full;
               end else if (lone_read && (rd_ptr_inc == ptr.write_ptr)) begin
                  next_state = fifo_state_pkg::st_empty;
               end
            end

            fifo_state_pkg::st_full: begin
               // no room left so only a pop is accepted
               ptr.read_ctr_en = pop_fifo;
               if (pop_fifo) begin
                  next_state = fifo_state_pkg::st_going_full;
               end
            end

            default: begin
               // illegal code
               // clear both counters and restart empty
               err               = 1'b1;
               ptr.read_ctr_rst  = 1'b1;
               ptr.write_ctr_rst = 1'b1;
               next_state        = fifo_state_pkg::st_empty;
            end
         endcase
      end
   end

   // state register
   always_ff @(posedge clk) begin
      if (rst) begin
         state <= fifo_state_pkg::st_empty;
      end else begin
         state <= next_state;
      end
   end

   // status flags follow the state being entered
   always_ff @(posedge clk) begin
      if (rst) begin
         fifo_empty <= 1'b1;
         fifo_full  <= 1'b0;
      end else begin
         fifo_empty <= (next_state == fifo_state_pkg::st_empty);
         fifo_full  <= (next_state == fifo_state_pkg::st_full);
      end
   end

   // one flag at most, and a flag is up exactly when the pointers have met
   assert property (@(posedge clk) disable iff (rst)
      !(fifo_empty && fifo_full) &&
      ((fifo_empty || fifo_full) == (ptr.read_ptr == ptr.write_ptr)))
      else $error("fifo flags disagree with the pointers");

   // counters must hold still while reset is applied
   assert property (@(posedge clk) rst |-> !(ptr.read_ctr_en || ptr.write_ctr_en))
      else $error("counter enable high during reset");

endmodule

/* fifo_ptr_if.sv */
`timescale 1ns/100ps

`include "fifo_defines.svh"

interface fifo_ptr_if;

   // current pointer values from the counters
   fifo_data_pkg::fifo_ptr_t read_ptr;
   fifo_data_pkg::fifo_ptr_t write_ptr;

   // increment strobes from the fsm
   logic read_ctr_en;
   logic write_ctr_en;

   // recovery clears from the fsm
   logic read_ctr_rst;
   logic write_ctr_rst;

   // fsm side
   modport fsm_mp (
      input  read_ptr, write_ptr,
      output read_ctr_en, write_ctr_en, read_ctr_rst, write_ctr_rst
   );

   // counter side
   modport ctr_mp (
      input  read_ctr_en, write_ctr_en, read_ctr_rst, write_ctr_rst,
      output read_ptr, write_ptr
   );

endinterface

/* fifo_state_pkg.sv */
`include "fifo_defines.svh"

package fifo_state_pkg;

   // control states of the fifo
   // code 2'b10 is not a member and is treated as illegal
   typedef enum logic [1:0] {
      st_empty      = 2'b00,
      st_going_full = 2'b01,
      st_full       = 2'b11
   } fifo_state_t;

endpackage

/* fifo_data_pkg.sv */
`include "fifo_defines.svh"

package fifo_data_pkg;

   // one word as it sits in the storage array
   typedef logic [`FIFO_DATA_W-1:0] fifo_word_t;

   // read or write address into the storage array
   // wraps naturally at the fifo depth
   typedef logic [`FIFO_PTR_W-1:0] fifo_ptr_t;

endpackage

/* fifo_defines.svh */
`ifndef FIFO_DEFINES_SVH
`define FIFO_DEFINES_SVH

// width of one stored data word
`define FIFO_DATA_W 8

// pointer width
// depth is 2 to the power of this value
`define FIFO_PTR_W 2

`endif
